// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log for the pass line
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
	--top-module tb_rv_soc \
	-f rv_soc.f \
	-o tb_rv_soc

# The grep below decides the result, so a stopped simulation still reaches it
./obj_dir/tb_rv_soc | tee "$LOG"

if grep -q "^PASS: all tests$" "$LOG"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: rv_alu.sv
`timescale 1ns/1ps

module rv_alu
	import rv_pkg::*;
(
	input alu_op_t alu_op_i,
	input word_t din1_i,
	input word_t din2_i,
	output word_t dout_o,
	output logic zero_o
);
	word_t diff;
	logic [4:0] shamt;

	assign diff = din1_i - din2_i;
	assign shamt = din2_i[4:0];

	always_comb begin
		case (alu_op_i)
		ALU_ADD:
			dout_o = din1_i + din2_i;
		ALU_SUB:
			dout_o = diff;
		ALU_AND:
			dout_o = din1_i & din2_i;
		ALU_OR:
			dout_o = din1_i | din2_i;
		ALU_XOR:
			dout_o = din1_i ^ din2_i;
		ALU_SLT:
			dout_o = {31'b0, $signed(din1_i) < $signed(din2_i)};
		ALU_SLL:
			dout_o = din1_i << shamt;
		ALU_SRL:
			dout_o = din1_i >> shamt; // Logical shift, SRA is not in the subset
		ALU_PASS2:
			dout_o = din2_i;
		default:
			dout_o = '0;
		endcase
	end

	// Branches compare by subtraction
	assign zero_o = (diff == '0);

endmodule

// File: rv_control.sv
`timescale 1ns/1ps

module rv_control
	import rv_pkg::*;
(
	input logic clk_i,
	input logic rst_n_i,
	input instruction_t ir_i,
	input logic alu_zero_i,
	output ctrl_t ctrl_o,
	output logic halt_o
);
	core_state_t state;
	core_state_t state_next;
	logic is_ebreak;
	logic branch_taken;
	alu_op_t arith_op;

	// Shared by OP_IMM and OP_REG, only OP_REG may select SUB
	function automatic alu_op_t decode_alu_op(logic [2:0] funct3, logic alt);
		case (funct3)
		F3_ADD_SUB: decode_alu_op = alt ? ALU_SUB : ALU_ADD;
		F3_SLL: decode_alu_op = ALU_SLL;
		F3_SLT: decode_alu_op = ALU_SLT;
		F3_XOR: decode_alu_op = ALU_XOR;
		F3_SRL: decode_alu_op = ALU_SRL;
		F3_OR: decode_alu_op = ALU_OR;
		F3_AND: decode_alu_op = ALU_AND;
		default: decode_alu_op = ALU_PASS2; // Marks an unsupported funct3
		endcase
	endfunction

	assign arith_op = decode_alu_op(ir_i.common.funct3,
		(ir_i.common.opcode == OP_REG) && ir_i.common.funct7[5]);

	assign is_ebreak = (ir_i.common.opcode == OP_SYSTEM) && (ir_i.itype.funct3 == 3'b000) &&
		(ir_i.itype.imm == 12'h001);

	always_comb begin
		case (ir_i.btype.funct3)
		F3_BEQ: branch_taken = alu_zero_i;
		F3_BNE: branch_taken = !alu_zero_i;
		default: branch_taken = 1'b0;
		endcase
	end

	// --------------------------------------------------
	// State register

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state <= ST_FETCH;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		case (state)
		ST_FETCH: state_next = ST_EXECUTE;
		ST_EXECUTE: state_next = is_ebreak ? ST_HALT : ST_FETCH;
		ST_HALT: state_next = ST_HALT; // Only reset leaves here
		default: state_next = ST_FETCH;
		endcase
	end

	assign halt_o = (state == ST_HALT);

	// --------------------------------------------------
	// Decoder

	always_comb begin
		ctrl_o.pc_we = 1'b0;
		ctrl_o.ir_we = 1'b0;
		ctrl_o.regfile_we = 1'b0;
		ctrl_o.mem_we = 1'b0;
		ctrl_o.next_pc_sel = NEXT_PC_SEL_PC_4;
		ctrl_o.regfile_in_sel = REGFILE_IN_SEL_ALU_OUT;
		ctrl_o.mem_rd_addr_sel = MEM_RD_ADDR_SEL_PC;
		ctrl_o.alu_op = ALU_PASS2;
		ctrl_o.alu_in2_sel = ALU_IN2_SEL_REGFILE_OUT2;
		ctrl_o.imm_sel = IMM_SEL_BTYPE;

		if (state == ST_FETCH) begin
			ctrl_o.ir_we = 1'b1;
		end else if (state == ST_EXECUTE) begin
			ctrl_o.pc_we = !is_ebreak; // PC holds on the EBREAK
			case (ir_i.common.opcode)
			OP_LUI: begin
				ctrl_o.alu_op = ALU_ADD; // Operand 1 is forced to zero
				ctrl_o.alu_in2_sel = ALU_IN2_SEL_UTYPE_IMM;
				ctrl_o.regfile_we = 1'b1;
			end
			OP_JAL: begin
				ctrl_o.imm_sel = IMM_SEL_JTYPE;
				ctrl_o.next_pc_sel = NEXT_PC_SEL_BRANCH;
				ctrl_o.regfile_in_sel = REGFILE_IN_SEL_PC_4;
				ctrl_o.regfile_we = 1'b1;
			end
			OP_BRANCH: begin
				ctrl_o.alu_op = ALU_SUB;
				ctrl_o.next_pc_sel = branch_taken ? NEXT_PC_SEL_BRANCH : NEXT_PC_SEL_PC_4;
			end
			OP_LOAD: begin
				ctrl_o.alu_op = ALU_ADD;
				ctrl_o.alu_in2_sel = ALU_IN2_SEL_ITYPE_IMM;
				ctrl_o.mem_rd_addr_sel = MEM_RD_ADDR_SEL_ALU_OUT;
				ctrl_o.regfile_in_sel = REGFILE_IN_SEL_MEM;
				ctrl_o.regfile_we = 1'b1;
			end
			OP_STORE: begin
				ctrl_o.alu_op = ALU_ADD;
				ctrl_o.alu_in2_sel = ALU_IN2_SEL_STYPE_IMM;
				ctrl_o.mem_we = 1'b1;
			end
			OP_IMM: begin
				ctrl_o.alu_op = arith_op;
				ctrl_o.alu_in2_sel = ALU_IN2_SEL_ITYPE_IMM;
				ctrl_o.regfile_we = (arith_op != ALU_PASS2);
			end
			OP_REG: begin
				ctrl_o.alu_op = arith_op;
				ctrl_o.regfile_we = (arith_op != ALU_PASS2);
			end
			default: ; // Unknown opcodes only advance the PC
			endcase
		end
	end

	// --------------------------------------------------
	// Assertions

	a_we_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(ctrl_o.pc_we && ctrl_o.ir_we))
		else $error("PC and IR written in the same cycle");

	a_store_in_execute: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		ctrl_o.mem_we |-> (state == ST_EXECUTE))
		else $error("memory write outside ST_EXECUTE");

	a_halt_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(state == ST_HALT) |=> (state == ST_HALT))
		else $error("core left ST_HALT without reset");

endmodule

// File: rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// --------------------------------------------------
// Memory geometry

// Depth of the unified instruction and data memory in 32-bit words
`define RV_MEM_WORDS 256

// Width of the word index into the memory
`define RV_MEM_AW 8

// --------------------------------------------------
// Core start-up

// Byte address of the first instruction fetched after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: rv_datapath.sv
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_datapath
	import rv_pkg::*;
(
	input logic clk_i,
	input logic rst_n_i,
	output word_t mem_rd_addr_o,
	input word_t mem_rd_data_i,
	output word_t mem_wr_addr_o,
	output word_t mem_wr_data_o,
	output logic mem_wr_en_o,
	output logic halt_o
);
	word_t pc;
	instruction_t ir;
	ctrl_t ctrl;

	word_t pc_4;
	word_t next_pc;
	word_t branch_imm;
	word_t branch_target;

	word_t rf_rin;
	word_t rf_rout1;
	word_t rf_rout2;

	word_t alu_din1;
	word_t alu_din2;
	word_t alu_dout;
	logic alu_zero;

	rv_regfile i_rv_regfile (
		.clk_i(clk_i),
		.rs1_i(ir.common.rs1),
		.rs2_i(ir.common.rs2),
		.rd_i(ir.common.rd),
		.rin_i(rf_rin),
		.we_i(ctrl.regfile_we),
		.rout1_o(rf_rout1),
		.rout2_o(rf_rout2)
	);

	rv_alu i_rv_alu (
		.alu_op_i(ctrl.alu_op),
		.din1_i(alu_din1),
		.din2_i(alu_din2),
		.dout_o(alu_dout),
		.zero_o(alu_zero)
	);

	rv_control i_rv_control (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.ir_i(ir),
		.alu_zero_i(alu_zero),
		.ctrl_o(ctrl),
		.halt_o(halt_o)
	);

	// --------------------------------------------------
	// Next PC

	always_comb begin
		if (ctrl.imm_sel == IMM_SEL_JTYPE) begin
			branch_imm = {{11{ir.jtype.imm_20}}, ir.jtype.imm_20, ir.jtype.imm_19_12,
				ir.jtype.imm_11, ir.jtype.imm_10_1, 1'b0};
		end else begin
			branch_imm = {{19{ir.btype.imm_12}}, ir.btype.imm_12, ir.btype.imm_11,
				ir.btype.imm_10_5, ir.btype.imm_4_1, 1'b0};
		end
	end

	assign pc_4 = pc + 32'd4;
	assign branch_target = pc + branch_imm; // Own adder, the ALU is busy comparing
	assign next_pc = (ctrl.next_pc_sel == NEXT_PC_SEL_BRANCH) ? branch_target : pc_4;

	// --------------------------------------------------
	// Operand and writeback muxes

	assign alu_din1 = (ctrl.alu_in2_sel == ALU_IN2_SEL_UTYPE_IMM) ? '0 : rf_rout1;

	always_comb begin
		case (ctrl.alu_in2_sel)
		ALU_IN2_SEL_ITYPE_IMM: alu_din2 = {{20{ir.itype.imm[11]}}, ir.itype.imm};
		ALU_IN2_SEL_STYPE_IMM: alu_din2 = {{20{ir.stype.imm_hi[6]}}, ir.stype.imm_hi,
			ir.stype.imm_lo};
		ALU_IN2_SEL_UTYPE_IMM: alu_din2 = {ir.utype.imm, 12'b0};
		default: alu_din2 = rf_rout2;
		endcase
	end

	always_comb begin
		case (ctrl.regfile_in_sel)
		REGFILE_IN_SEL_MEM: rf_rin = mem_rd_data_i;
		REGFILE_IN_SEL_PC_4: rf_rin = pc_4; // JAL link
		default: rf_rin = alu_dout;
		endcase
	end

	assign mem_rd_addr_o = (ctrl.mem_rd_addr_sel == MEM_RD_ADDR_SEL_ALU_OUT) ? alu_dout : pc;
	assign mem_wr_addr_o = alu_dout;
	assign mem_wr_data_o = rf_rout2;
	assign mem_wr_en_o = ctrl.mem_we;

	// --------------------------------------------------
	// PC and IR

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			pc <= `RV_RESET_PC;
		end else if (ctrl.pc_we) begin
			pc <= next_pc;
		end
	end

	always_ff @(posedge clk_i) begin
		if (ctrl.ir_we) begin
			ir <= mem_rd_data_i;
		end
	end

	a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i) pc[1:0] == 2'b00)
		else $error("PC not word aligned: %h", pc);

endmodule

// File: rv_memory.sv
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_memory
	import rv_pkg::*;
(
	input logic clk_i,
	input logic rst_n_i,
	input word_t rd_addr_i,
	output word_t rd_data_o,
	input word_t wr_addr_i,
	input word_t wr_data_i,
	input logic wr_en_i,
	input logic load_we_i,
	input logic [`RV_MEM_AW-1:0] load_addr_i,
	input word_t load_data_i
);
	word_t mem [`RV_MEM_WORDS];
	logic [`RV_MEM_AW-1:0] rd_index;
	logic [`RV_MEM_AW-1:0] wr_index;

	// Byte addresses, the low two bits are dropped
	assign rd_index = rd_addr_i[`RV_MEM_AW+1:2];
	assign wr_index = wr_addr_i[`RV_MEM_AW+1:2];

	assign rd_data_o = mem[rd_index];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			if (load_we_i) begin
				mem[load_addr_i] <= load_data_i; // Program load while the core is held
			end
		end else if (wr_en_i) begin
			mem[wr_index] <= wr_data_i;
		end
	end

	// --------------------------------------------------
	// Assertions

	// The core has no misaligned-store trap, so a bad address would silently alias
	a_store_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wr_en_i |-> (wr_addr_i[1:0] == 2'b00))
		else $error("misaligned store to %h", wr_addr_i);

endmodule

// File: rv_pkg.sv
package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// --------------------------------------------------
	// Instruction encodings

	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_JAL    = 7'b1101111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011,
		OP_SYSTEM = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {
		F3_ADD_SUB = 3'b000,
		F3_SLL     = 3'b001,
		F3_SLT     = 3'b010,
		F3_XOR     = 3'b100,
		F3_SRL     = 3'b101,
		F3_OR      = 3'b110,
		F3_AND     = 3'b111
	} alu_funct3_t;

	typedef enum logic [2:0] {
		F3_BEQ = 3'b000,
		F3_BNE = 3'b001
	} branch_funct3_t;

	// --------------------------------------------------
	// Datapath controls

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_PASS2
	} alu_op_t;

	typedef enum logic {NEXT_PC_SEL_PC_4, NEXT_PC_SEL_BRANCH} next_pc_sel_t;

	typedef enum logic [1:0] {
		REGFILE_IN_SEL_ALU_OUT, REGFILE_IN_SEL_MEM, REGFILE_IN_SEL_PC_4
	} regfile_in_sel_t;

	typedef enum logic {MEM_RD_ADDR_SEL_PC, MEM_RD_ADDR_SEL_ALU_OUT} mem_rd_addr_sel_t;

	typedef enum logic [1:0] {
		ALU_IN2_SEL_REGFILE_OUT2, ALU_IN2_SEL_ITYPE_IMM, ALU_IN2_SEL_STYPE_IMM,
		ALU_IN2_SEL_UTYPE_IMM
	} alu_in2_sel_t;

	typedef enum logic {IMM_SEL_BTYPE, IMM_SEL_JTYPE} imm_sel_t;

	typedef enum logic [1:0] {ST_FETCH, ST_EXECUTE, ST_HALT} core_state_t;

	// --------------------------------------------------
	// Instruction formats, all 32 bits wide

	typedef union packed {
		struct packed {
			logic [6:0] funct7; reg_addr_t rs2; reg_addr_t rs1;
			logic [2:0] funct3; reg_addr_t rd; opcode_t opcode;
		} common;
		struct packed {
			logic [11:0] imm; reg_addr_t rs1; logic [2:0] funct3; reg_addr_t rd; opcode_t opcode;
		} itype;
		struct packed {
			logic [6:0] imm_hi; reg_addr_t rs2; reg_addr_t rs1;
			logic [2:0] funct3; logic [4:0] imm_lo; opcode_t opcode;
		} stype;
		struct packed {
			logic imm_12; logic [5:0] imm_10_5; reg_addr_t rs2; reg_addr_t rs1;
			logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; opcode_t opcode;
		} btype;
		struct packed {
			logic [19:0] imm; reg_addr_t rd; opcode_t opcode;
		} utype;
		struct packed {
			logic imm_20; logic [9:0] imm_10_1; logic imm_11; logic [7:0] imm_19_12;
			reg_addr_t rd; opcode_t opcode;
		} jtype;
	} instruction_t;

	typedef struct packed {
		logic pc_we;
		logic ir_we;
		logic regfile_we;
		logic mem_we;
		next_pc_sel_t next_pc_sel;
		regfile_in_sel_t regfile_in_sel;
		mem_rd_addr_sel_t mem_rd_addr_sel;
		alu_op_t alu_op;
		alu_in2_sel_t alu_in2_sel;
		imm_sel_t imm_sel;
	} ctrl_t;

endpackage

// File: rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile
	import rv_pkg::*;
(
	input logic clk_i,
	input reg_addr_t rs1_i,
	input reg_addr_t rs2_i,
	input reg_addr_t rd_i,
	input word_t rin_i,
	input logic we_i,
	output word_t rout1_o,
	output word_t rout2_o
);
	word_t regs [32];

	always_ff @(posedge clk_i) begin
		if (we_i && (rd_i != '0)) begin
			regs[rd_i] <= rin_i; // x0 is never written
		end
	end

	// x0 is hardwired in the read path
	assign rout1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
	assign rout2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

	// --------------------------------------------------
	// Assertions

	a_x0_port1: assert property (@(posedge clk_i) (rs1_i == '0) |-> (rout1_o == '0))
		else $error("x0 read nonzero on port 1");

	a_x0_port2: assert property (@(posedge clk_i) (rs2_i == '0) |-> (rout2_o == '0))
		else $error("x0 read nonzero on port 2");

endmodule

// File: rv_soc.f
+incdir+.
rv_pkg.sv
rv_regfile.sv
rv_alu.sv
rv_control.sv
rv_datapath.sv
rv_memory.sv
rv_soc.sv
tb_rv_soc.sv

// File: rv_soc.sv
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_soc
	import rv_pkg::*;
(
	input logic clk_i,
	input logic rst_n_i,
	input logic load_we_i,
	input logic [`RV_MEM_AW-1:0] load_addr_i,
	input word_t load_data_i,
	output logic mem_wr_en_o,
	output word_t mem_wr_addr_o,
	output word_t mem_wr_data_o,
	output logic halt_o
);
	word_t mem_rd_addr;
	word_t mem_rd_data;

	rv_datapath i_rv_datapath (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.mem_rd_addr_o(mem_rd_addr),
		.mem_rd_data_i(mem_rd_data),
		.mem_wr_addr_o(mem_wr_addr_o), // Store bus is also the top-level output
		.mem_wr_data_o(mem_wr_data_o),
		.mem_wr_en_o(mem_wr_en_o),
		.halt_o(halt_o)
	);

	rv_memory i_rv_memory (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.rd_addr_i(mem_rd_addr),
		.rd_data_o(mem_rd_data),
		.wr_addr_i(mem_wr_addr_o),
		.wr_data_i(mem_wr_data_o),
		.wr_en_i(mem_wr_en_o),
		.load_we_i(load_we_i),
		.load_addr_i(load_addr_i),
		.load_data_i(load_data_i)
	);

endmodule

// File: tb_rv_soc.sv
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module tb_rv_soc;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
	} store_t;

	localparam logic [31:0] DATA_BASE = 32'h0000_0200;
	localparam logic [31:0] MARKER_ADDR = 32'h0000_03fc; // Only wrong-path code stores here
	localparam logic [6:0] OPC_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;

	logic clk;
	logic rst_n;
	logic rst_q;
	logic armed;
	logic load_we;
	logic [`RV_MEM_AW-1:0] load_addr;
	logic [31:0] load_data;
	logic mem_wr_en;
	logic [31:0] mem_wr_addr;
	logic [31:0] mem_wr_data;
	logic halt;

	logic [31:0] prog [$];
	store_t exp_q [$];
	store_t exp_head;
	int exp_left;
	logic [31:0] rng_state;
	logic [31:0] data_addr;
	int errors;
	int cycle;
	int run_limit;

	rv_soc i_rv_soc (
		.clk_i(clk),
		.rst_n_i(rst_n),
		.load_we_i(load_we),
		.load_addr_i(load_addr),
		.load_data_i(load_data),
		.mem_wr_en_o(mem_wr_en),
		.mem_wr_addr_o(mem_wr_addr),
		.mem_wr_data_o(mem_wr_data),
		.halt_o(halt)
	);

	always #5 clk = ~clk;

	// --------------------------------------------------
	// Instruction encoders and random source

	function automatic logic [31:0] enc_u(logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] enc_i(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
		logic [11:0] imm, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
		logic [4:0] rs1, logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_s(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] off);
		return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
		logic [31:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(logic [4:0] rd, logic [31:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] xorshift(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic logic [11:0] rand_imm();
		logic [31:0] r;
		r = next_rand();
		return r[11:0];
	endfunction

	function automatic logic [31:0] sext12(logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	function automatic logic [31:0] signed_less(logic [31:0] x, logic [31:0] y);
		if (x[31] != y[31]) begin
			return {31'b0, x[31]}; // Opposite signs order by the sign bit alone
		end
		return {31'b0, x < y};
	endfunction

	// --------------------------------------------------
	// Program assembly

	function automatic logic [31:0] here();
		return 32'(prog.size()) * 32'd4; // Byte address of the next instruction
	endfunction

	task automatic set_reg(logic [4:0] rd, logic [31:0] value);
		logic [31:0] upper;
		upper = value + 32'h800; // ADDI sign-extends, so round the upper part
		prog.push_back(enc_u(rd, upper[31:12]));
		prog.push_back(enc_i(3'b000, rd, rd, value[11:0], OPC_IMM));
	endtask

	task automatic store_reg(logic [4:0] rs2, logic [31:0] value);
		prog.push_back(enc_s(rs2, 5'd0, data_addr[11:0]));
		exp_q.push_back({data_addr, value});
		data_addr = data_addr + 32'd4;
	endtask

	task automatic emit_marker();
		prog.push_back(enc_s(5'd5, 5'd0, MARKER_ADDR[11:0]));
	endtask

	task automatic check_reg_op(logic [6:0] f7, logic [2:0] f3, logic [31:0] expected);
		prog.push_back(enc_r(f7, f3, 5'd3, 5'd1, 5'd2));
		store_reg(5'd3, expected);
	endtask

	task automatic check_imm_op(logic [2:0] f3, logic [11:0] imm, logic [31:0] expected);
		prog.push_back(enc_i(f3, 5'd3, 5'd1, imm, OPC_IMM));
		store_reg(5'd3, expected);
	endtask

	task automatic build_program();
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] imm;
		logic [31:0] link;
		logic [31:0] rt_addr;
		a = next_rand();
		b = next_rand();
		set_reg(5'd1, a);
		set_reg(5'd2, b);
		check_reg_op(7'h00, 3'b000, a + b);
		check_reg_op(7'h20, 3'b000, a - b);
		check_reg_op(7'h00, 3'b111, a & b);
		check_reg_op(7'h00, 3'b110, a | b);
		check_reg_op(7'h00, 3'b100, a ^ b);
		check_reg_op(7'h00, 3'b010, signed_less(a, b));
		check_reg_op(7'h00, 3'b001, a << b[4:0]);
		check_reg_op(7'h00, 3'b101, a >> b[4:0]);
		imm = rand_imm();
		check_imm_op(3'b000, imm, a + sext12(imm));
		imm = rand_imm();
		check_imm_op(3'b111, imm, a & sext12(imm));
		imm = rand_imm();
		check_imm_op(3'b110, imm, a | sext12(imm));
		imm = rand_imm();
		check_imm_op(3'b100, imm, a ^ sext12(imm));
		imm = rand_imm();
		check_imm_op(3'b010, imm, signed_less(a, sext12(imm)));

		rt_addr = data_addr; // Load round trip through memory
		store_reg(5'd1, a);
		prog.push_back(enc_i(3'b010, 5'd4, 5'd0, rt_addr[11:0], OPC_LOAD));
		store_reg(5'd4, a);

		prog.push_back(enc_i(3'b000, 5'd5, 5'd0, 12'd1, OPC_IMM));
		prog.push_back(enc_b(3'b000, 5'd1, 5'd1, 32'd8)); // BEQ taken
		emit_marker();
		store_reg(5'd5, 32'd1);
		prog.push_back(enc_b(3'b000, 5'd0, 5'd5, 32'd8)); // BEQ not taken
		store_reg(5'd5, 32'd1);
		prog.push_back(enc_b(3'b001, 5'd0, 5'd5, 32'd8)); // BNE taken
		emit_marker();
		prog.push_back(enc_b(3'b001, 5'd5, 5'd5, 32'd8)); // BNE not taken
		store_reg(5'd5, 32'd1);
		link = here() + 32'd4;
		prog.push_back(enc_j(5'd6, 32'd8));
		emit_marker();
		store_reg(5'd6, link);

		prog.push_back(enc_i(3'b000, 5'd0, 5'd0, rand_imm(), OPC_IMM)); // x0 must stay zero
		store_reg(5'd0, 32'd0);
		prog.push_back(32'h0010_0073); // EBREAK
		emit_marker();
	endtask

	// --------------------------------------------------
	// Expected-store queue head and checks

	always @(posedge clk) begin
		if (rst_n && mem_wr_en && exp_q.size() != 0) begin
			void'(exp_q.pop_front());
		end
		exp_left <= exp_q.size();
		if (exp_q.size() != 0) begin
			exp_head <= exp_q[0];
		end
		rst_q <= rst_n;
		armed <= 1'b1;
	end

	a_quiet_reset: assert property (@(posedge clk) (armed && (!rst_n || !rst_q)) |->
		(!mem_wr_en && !halt))
		else begin
			errors++;
			$display("CHECK FAILED at %0t: store or halt active around reset", $time);
		end

	a_store_match: assert property (@(posedge clk) disable iff (!rst_n)
		mem_wr_en |-> (exp_left != 0 && mem_wr_addr == exp_head.addr &&
		mem_wr_data == exp_head.data))
		else begin
			errors++;
			$display("CHECK FAILED at %0t: store %h <= %h, expected %h <= %h (%0d left)",
				$time, mem_wr_addr, mem_wr_data, exp_head.addr, exp_head.data, exp_left);
		end

	a_no_marker: assert property (@(posedge clk) disable iff (!rst_n)
		mem_wr_en |-> (mem_wr_addr != MARKER_ADDR))
		else begin
			errors++;
			$display("CHECK FAILED at %0t: wrong-path store reached memory", $time);
		end

	a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt)
		else begin
			errors++;
			$display("CHECK FAILED at %0t: halt dropped without reset", $time);
		end

	a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n) halt |-> !mem_wr_en)
		else begin
			errors++;
			$display("CHECK FAILED at %0t: store strobe while halted", $time);
		end

	a_all_stored: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(halt) |-> (exp_left == 0))
		else begin
			errors++;
			$display("CHECK FAILED at %0t: halted with %0d stores missing", $time, exp_left);
		end

	// --------------------------------------------------
	// Load, reset and run

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		rst_q = 1'b0;
		armed = 1'b0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		errors = 0;
		cycle = 0;
		rng_state = 32'h7cee;
		data_addr = DATA_BASE;
		build_program();
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			load_we <= 1'b1;
			load_addr <= i[`RV_MEM_AW-1:0];
			load_data <= prog[i];
		end
		@(posedge clk);
		load_we <= 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		run_limit = 2 * prog.size() + 50; // Two cycles per instruction plus margin
		while (!halt && cycle < run_limit) begin
			@(posedge clk);
			cycle++;
		end
		if (!halt) begin
			errors++;
			$display("Timeout: core did not halt within %0d cycles", run_limit);
		end else begin
			repeat (5) @(posedge clk); // Halt must hold with no late stores
		end
		$display("Run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
